/* list.f */
rs_pkg.sv
rename_table.sv
station_entries.sv
issue_encoder.sv
rs_top.sv
rs_checker.sv
tb_rs.sv

/* tb_rs.sv */
`timescale 1ns/1ps

module tb_rs;
  import rs_pkg::*;

  localparam int N_ROUNDS    = 60;
  localparam int STIM_CYCLES = N_ROUNDS * 40 + 600;

  logic       clk;
  logic       rst;
  logic       disp_valid;
  tag_t       disp_tag;
  opcode_t    disp_opcode;
  func3_t     disp_func3;
  func7_t     disp_func7;
  word_t      disp_imm;
  reg_idx_t   disp_rs1;
  reg_idx_t   disp_rs2;
  reg_idx_t   disp_rd;
  word_t      disp_pc;
  logic       disp_hold;
  logic       cdb_valid;
  tag_t       cdb_tag;
  word_t      cdb_value;
  logic       commit_valid;
  reg_idx_t   commit_rd;
  tag_t       commit_tag;
  word_t      commit_value;
  logic       flush;
  logic       alu_full;
  logic       push_valid;
  tag_t       push_tag;
  logic       alu_valid;
  calc_code_t alu_code;
  word_t      alu_lhs;
  word_t      alu_rhs;
  tag_t       alu_tag;
  logic       wb_valid;
  tag_t       wb_tag;
  word_t      wb_result;
  logic       wb_target_valid;
  word_t      wb_target;

  int       ck_errors;
  int       ck_checks;
  int       ck_open;
  int       tb_errors;
  tag_t     next_tag;
  logic     hold_noise;
  logic     accepted;
  opcode_t  direct_op;
  logic     issued  [IQ_DEPTH];
  word_t    res_val [IQ_DEPTH];
  reg_idx_t rd_of   [IQ_DEPTH];
  tag_t     cdb_q   [$];
  tag_t     round_q [$];

  rs_top i_dut (.*);

  rs_checker i_check (.*, .errors(ck_errors), .checks(ck_checks), .open_items(ck_open));

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    #(STIM_CYCLES * 4 * 4);
    $display("Watchdog timeout, the run did not finish within %0d ns", STIM_CYCLES * 16);
    $display("Test failures found");
    $finish;
  end

  // acts as the alu and the queue, every issued tag gets a cdb result
  always @(posedge clk) begin
    if (!rst && alu_valid) begin
      issued[alu_tag]  = 1'b1;
      res_val[alu_tag] = $urandom;
      cdb_q.push_back(alu_tag);
    end
    if (!rst && wb_valid) begin
      issued[wb_tag]  = 1'b1;
      res_val[wb_tag] = wb_result;
      cdb_q.push_back(wb_tag);
    end
  end

  // broadcast with a random delay
  always @(posedge clk) begin
    #1;
    if (cdb_q.size() > 0 && $urandom % 2 == 1) begin
      cdb_valid = 1'b1;
      cdb_tag   = cdb_q.pop_front();
      cdb_value = res_val[cdb_tag];
    end else begin
      cdb_valid = 1'b0;
    end
  end

  task automatic note_failure(input string msg);
    tb_errors++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  task automatic send(input opcode_t op, input func3_t f3, input func7_t f7, input word_t imm,
                      input reg_idx_t rs1, input reg_idx_t rs2, input reg_idx_t rd,
                      input word_t pc, output logic acc);
    disp_valid  = 1'b1;
    disp_tag    = next_tag;
    disp_opcode = op;
    disp_func3  = f3;
    disp_func7  = f7;
    disp_imm    = imm;
    disp_rs1    = rs1;
    disp_rs2    = rs2;
    disp_rd     = rd;
    disp_pc     = pc;
    disp_hold   = hold_noise && ($urandom % 8 == 0);
    @(posedge clk);
    #1;
    disp_valid = 1'b0;
    disp_hold  = 1'b0;
    acc        = push_valid;
    if (acc) begin
      issued[next_tag] = 1'b0;
      rd_of[next_tag]  = rd;
      round_q.push_back(next_tag);
      next_tag++;
    end
  endtask

  task automatic dispatch(input opcode_t op, input func3_t f3, input func7_t f7,
                          input word_t imm, input reg_idx_t rs1, input reg_idx_t rs2,
                          input reg_idx_t rd, input word_t pc);
    logic acc;
    acc = 1'b0;
    while (!acc) send(op, f3, f7, imm, rs1, rs2, rd, pc, acc);
  endtask

  function automatic logic all_issued();
    foreach (round_q[i]) if (!issued[round_q[i]]) return 1'b0;
    return 1'b1;
  endfunction

  // wait until every dispatched tag has issued and broadcast its result
  task automatic wait_results();
    alu_full = 1'b0;
    while (!all_issued() || cdb_q.size() != 0) @(posedge clk);
    @(posedge clk);
    #1;
  endtask

  task automatic commit_result(input tag_t t);
    commit_valid = 1'b1;
    commit_tag   = t;
    commit_rd    = rd_of[t];
    commit_value = res_val[t];
    @(posedge clk);
    #1;
    commit_valid = 1'b0;
  endtask

  // wait for every dispatched tag, then commit them in program order
  task automatic drain();
    wait_results();
    foreach (round_q[i]) commit_result(round_q[i]);
    round_q.delete();
  endtask

  task automatic random_instr();
    opcode_t op;
    func3_t  f3;
    case ($urandom % 7)
      0:       op = OPC_LUI;
      1:       op = OPC_AUIPC;
      2:       op = OPC_JAL;
      3:       op = OPC_JALR;
      4:       op = OPC_BRANCH;
      5:       op = OPC_CALC_I;
      default: op = OPC_CALC;
    endcase
    f3 = func3_t'($urandom);
    // branches have no func3 2 or 3
    if (op == OPC_BRANCH && f3[2:1] == 2'b01) f3[1] = 1'b0;
    alu_full = ($urandom % 4 == 0);
    dispatch(op, f3, ($urandom % 2) ? 7'h20 : 7'h00, $urandom, reg_idx_t'($urandom % 8),
             reg_idx_t'($urandom % 8), reg_idx_t'($urandom % 8), $urandom & 32'hffff_fffc);
  endtask

  task automatic run_round();
    int n;
    n = 1 + $urandom % 6;
    repeat (n) random_instr();
    drain();
  endtask

  initial begin
    void'($urandom(32'h422c));
    {disp_valid, disp_hold, cdb_valid, commit_valid, flush, alu_full} = '0;
    {disp_tag, disp_opcode, disp_func3, disp_func7, disp_imm} = '0;
    {disp_rs1, disp_rs2, disp_rd, disp_pc} = '0;
    {cdb_tag, cdb_value, commit_rd, commit_tag, commit_value} = '0;
    tb_errors  = 0;
    next_tag   = '0;
    hold_noise = 1'b1;
    rst        = 1'b1;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    repeat (N_ROUNDS / 2) run_round();
    hold_noise = 1'b0;

    // direct ops reach the queue with fixed latency on an empty station
    for (int k = 0; k < 4; k++) begin
      case (k)
        0:       direct_op = OPC_LUI;
        1:       direct_op = OPC_AUIPC;
        2:       direct_op = OPC_JAL;
        default: direct_op = OPC_JALR;
      endcase
      dispatch(direct_op, 3'd0, 7'h00, $urandom, reg_idx_t'(1 + k), 5'd2, 5'd0,
               $urandom & 32'hffff_fffc);
      @(posedge clk);
      #1;
      if (!wb_valid || wb_tag != tag_t'(next_tag - 1'b1))
        note_failure("direct op missed the queue write two cycles after dispatch");
    end
    drain();

    // every decode case, random immediates exercise the shift mask
    for (int f3 = 0; f3 < 8; f3++) begin
      for (int f7 = 0; f7 < 2; f7++) begin
        dispatch(OPC_CALC, func3_t'(f3), f7 ? 7'h20 : 7'h00, $urandom, 5'd3, 5'd4, 5'd0, '0);
        dispatch(OPC_CALC_I, func3_t'(f3), f7 ? 7'h20 : 7'h00, $urandom, 5'd5, 5'd0, 5'd0, '0);
      end
      if (f3 != 2 && f3 != 3) dispatch(OPC_BRANCH, func3_t'(f3), 7'h00, $urandom, 5'd6, 5'd7,
                                       5'd0, '0);
    end
    drain();

    // back-pressure fills the station with held alu ops
    alu_full = 1'b1;
    dispatch(OPC_LUI, 3'd0, 7'h00, $urandom, 5'd0, 5'd0, 5'd1, '0);
    repeat (RS_DEPTH) dispatch(OPC_CALC, func3_t'($urandom), 7'h00, '0,
                               reg_idx_t'($urandom % 8), reg_idx_t'($urandom % 8),
                               reg_idx_t'(1 + $urandom % 7), '0);
    repeat (6) @(posedge clk);
    #1;
    if (!issued[round_q[0]]) note_failure("direct op did not issue while alu_full was high");
    for (int i = 1; i <= RS_DEPTH; i++)
      if (issued[round_q[i]]) note_failure("alu op issued while alu_full was high");
    send(OPC_LUI, 3'd0, 7'h00, '0, 5'd0, 5'd0, 5'd0, '0, accepted);
    if (accepted) note_failure("station accepted a dispatch while full");
    while (cdb_q.size() != 0) @(posedge clk);
    #1;
    flush = 1'b1;
    @(posedge clk);
    #1;
    flush    = 1'b0;
    alu_full = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    for (int i = 1; i <= RS_DEPTH; i++)
      if (issued[round_q[i]]) note_failure("flushed entry issued after the flush");
    round_q.delete();

    // an older commit leaves the newer rename of the same register in place
    dispatch(OPC_LUI, 3'd0, 7'h00, 32'h1234_5000, 5'd0, 5'd0, 5'd9, '0);
    dispatch(OPC_LUI, 3'd0, 7'h00, 32'h0abc_d000, 5'd0, 5'd0, 5'd9, '0);
    wait_results();
    commit_result(round_q.pop_front());
    dispatch(OPC_CALC, 3'd0, 7'h00, '0, 5'd9, 5'd0, 5'd0, '0);
    drain();

    repeat (N_ROUNDS / 2) run_round();
    repeat (4) @(posedge clk);
    #1;
    if (ck_open != 0) note_failure("entries were left in the station at the end");
    $display("Summary: %0d issue checks, %0d checker errors, %0d testbench errors",
             ck_checks, ck_errors, tb_errors);
    if (ck_errors + tb_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* rs_checker.sv */
`timescale 1ns/1ps

module rs_checker
  import rs_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       disp_valid,
  input  tag_t       disp_tag,
  input  opcode_t    disp_opcode,
  input  func3_t     disp_func3,
  input  func7_t     disp_func7,
  input  word_t      disp_imm,
  input  reg_idx_t   disp_rs1,
  input  reg_idx_t   disp_rs2,
  input  reg_idx_t   disp_rd,
  input  word_t      disp_pc,
  input  logic       cdb_valid,
  input  tag_t       cdb_tag,
  input  word_t      cdb_value,
  input  logic       commit_valid,
  input  reg_idx_t   commit_rd,
  input  tag_t       commit_tag,
  input  word_t      commit_value,
  input  logic       flush,
  input  logic       alu_full,
  input  logic       push_valid,
  input  tag_t       push_tag,
  input  logic       alu_valid,
  input  calc_code_t alu_code,
  input  word_t      alu_lhs,
  input  word_t      alu_rhs,
  input  tag_t       alu_tag,
  input  logic       wb_valid,
  input  tag_t       wb_tag,
  input  word_t      wb_result,
  input  logic       wb_target_valid,
  input  word_t      wb_target,
  output int         errors,
  output int         checks,
  output int         open_items
);

  // slot CAND holds the dispatch that is not yet acknowledged
  localparam int CAND = IQ_DEPTH;

  word_t m_val [REG_COUNT];
  logic  m_ren [REG_COUNT];
  tag_t  m_tag [REG_COUNT];
  word_t b_val [IQ_DEPTH];
  logic  b_ok  [IQ_DEPTH];

  logic    e_live [IQ_DEPTH+1];
  logic    e_rdy1 [IQ_DEPTH+1];
  logic    e_rdy2 [IQ_DEPTH+1];
  tag_t    e_src1 [IQ_DEPTH+1];
  tag_t    e_src2 [IQ_DEPTH+1];
  word_t   e_v1   [IQ_DEPTH+1];
  word_t   e_v2   [IQ_DEPTH+1];
  opcode_t e_op   [IQ_DEPTH+1];
  func3_t  e_f3   [IQ_DEPTH+1];
  func7_t  e_f7   [IQ_DEPTH+1];
  word_t   e_imm  [IQ_DEPTH+1];
  word_t   e_pc   [IQ_DEPTH+1];
  int      e_cyc  [IQ_DEPTH+1];

  int       cycle;
  logic     prev_full;
  tag_t     c_tag;
  reg_idx_t c_rd;

  function automatic void resolve(input reg_idx_t r, output logic rdy, output word_t val,
                                  output tag_t src);
    src = m_tag[r];
    rdy = 1'b1;
    val = m_val[r];
    if (r == 0) begin
      val = '0;
    end else if (m_ren[r]) begin
      if (cdb_valid && cdb_tag == src) val = cdb_value;
      else if (commit_valid && commit_tag == src) val = commit_value;
      else if (b_ok[src]) val = b_val[src];
      else rdy = 1'b0;
    end
  endfunction

  // expected issue packet for one resolved entry
  function automatic void expect_packet(input opcode_t op, input func3_t f3, input func7_t f7,
                                        input word_t lhs, input word_t rhs, input word_t imm,
                                        input word_t pc, output logic alu,
                                        output calc_code_t code, output word_t arhs,
                                        output word_t res, output logic tv, output word_t tgt);
    alu = op inside {OPC_CALC, OPC_CALC_I, OPC_BRANCH};
    if (op == OPC_BRANCH) code = (f3 < 2) ? 4'(f3) + 4'd10 : 4'(f3) + 4'd8;
    else if (f3 == 0) code = (op == OPC_CALC && f7 != 0) ? CALC_SUB : CALC_ADD;
    else if (f3 == 5) code = (f7 != 0) ? CALC_SRA : CALC_SRL;
    else if (f3 <= 4) code = 4'(f3) + 4'd1;
    else code = 4'(f3) + 4'd2;
    arhs = (op == OPC_CALC_I) ? imm : rhs;
    if (op != OPC_BRANCH && (f3 == 1 || f3 == 5)) arhs = arhs & word_t'((1 << SHAMT_BITS) - 1);
    if (op == OPC_LUI) res = imm;
    else if (op == OPC_AUIPC) res = pc + imm;
    else res = pc + 32'd4;
    tv  = (op == OPC_JALR);
    tgt = (lhs + imm) & ~32'd1;
  endfunction

  task automatic flag_error(input string msg);
    errors++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  task automatic expect_eq(input tag_t t, input string what, input word_t got, input word_t exp);
    if (got !== exp) flag_error($sformatf("tag %0d %s got %h expected %h", t, what, got, exp));
  endtask

  task automatic check_issue(input tag_t t, input logic on_alu);
    logic       alu;
    logic       tv;
    calc_code_t code;
    word_t      arhs;
    word_t      res;
    word_t      tgt;
    checks++;
    if (!e_live[t] || !e_rdy1[t] || !e_rdy2[t]) begin
      flag_error($sformatf("tag %0d issued without a ready entry in the station", t));
    end else begin
      expect_packet(e_op[t], e_f3[t], e_f7[t], e_v1[t], e_v2[t], e_imm[t], e_pc[t],
                    alu, code, arhs, res, tv, tgt);
      if (alu != on_alu) begin
        flag_error($sformatf("tag %0d issued on the wrong port", t));
      end else if (on_alu) begin
        expect_eq(t, "alu_code", alu_code, code);
        expect_eq(t, "alu_lhs", alu_lhs, e_v1[t]);
        expect_eq(t, "alu_rhs", alu_rhs, arhs);
      end else begin
        expect_eq(t, "wb_result", wb_result, res);
        expect_eq(t, "wb_target_valid", wb_target_valid, tv);
        if (tv) expect_eq(t, "wb_target", wb_target, tgt);
      end
      if (cycle - e_cyc[t] < 2) flag_error($sformatf("tag %0d issued too early", t));
    end
    e_live[t] = 1'b0;
  endtask

  task automatic move_record(input tag_t t);
    e_live[t] = 1'b1;
    e_rdy1[t] = e_rdy1[CAND];
    e_rdy2[t] = e_rdy2[CAND];
    e_src1[t] = e_src1[CAND];
    e_src2[t] = e_src2[CAND];
    e_v1[t]   = e_v1[CAND];
    e_v2[t]   = e_v2[CAND];
    e_op[t]   = e_op[CAND];
    e_f3[t]   = e_f3[CAND];
    e_f7[t]   = e_f7[CAND];
    e_imm[t]  = e_imm[CAND];
    e_pc[t]   = e_pc[CAND];
    e_cyc[t]  = e_cyc[CAND];
  endtask

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        m_val[i] = '0;
        m_ren[i] = 1'b0;
        m_tag[i] = '0;
      end
      for (int i = 0; i <= IQ_DEPTH; i++) e_live[i] = 1'b0;
      for (int i = 0; i < IQ_DEPTH; i++) b_ok[i] = 1'b0;
      cycle     = 0;
      prev_full = 1'b0;
    end else begin
      cycle++;
      // outputs registered at the previous edge
      if (alu_valid && wb_valid) flag_error("alu request and queue write in the same cycle");
      if (alu_valid && prev_full) flag_error("alu request issued while alu_full was high");
      if (alu_valid) check_issue(alu_tag, 1'b1);
      if (wb_valid) check_issue(wb_tag, 1'b0);
      // acknowledgment of last cycle's dispatch applies its rename
      if (push_valid) begin
        if (!e_live[CAND] || push_tag != c_tag) begin
          flag_error("dispatch acknowledged without a matching request");
        end else begin
          move_record(c_tag);
          if (c_rd != 0) begin
            m_ren[c_rd] = 1'b1;
            m_tag[c_rd] = c_tag;
          end
          b_ok[c_tag] = 1'b0;
        end
      end
      e_live[CAND] = 1'b0;
      if (cdb_valid) begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
          if (e_live[i] && !e_rdy1[i] && e_src1[i] == cdb_tag) begin
            e_rdy1[i] = 1'b1;
            e_v1[i]   = cdb_value;
          end
          if (e_live[i] && !e_rdy2[i] && e_src2[i] == cdb_tag) begin
            e_rdy2[i] = 1'b1;
            e_v2[i]   = cdb_value;
          end
        end
      end
      if (disp_valid && !flush) begin
        e_live[CAND] = 1'b1;
        c_tag        = disp_tag;
        c_rd         = disp_rd;
        e_op[CAND]   = disp_opcode;
        e_f3[CAND]   = disp_func3;
        e_f7[CAND]   = disp_func7;
        e_imm[CAND]  = disp_imm;
        e_pc[CAND]   = disp_pc;
        e_cyc[CAND]  = cycle;
        resolve(disp_rs1, e_rdy1[CAND], e_v1[CAND], e_src1[CAND]);
        resolve(disp_rs2, e_rdy2[CAND], e_v2[CAND], e_src2[CAND]);
      end
      if (cdb_valid) begin
        b_ok[cdb_tag]  = 1'b1;
        b_val[cdb_tag] = cdb_value;
      end
      if (commit_valid) begin
        b_ok[commit_tag] = 1'b0;
        if (commit_rd != 0) begin
          m_val[commit_rd] = commit_value;
          if (m_ren[commit_rd] && m_tag[commit_rd] == commit_tag) m_ren[commit_rd] = 1'b0;
        end
      end
      if (flush) begin
        for (int i = 0; i < REG_COUNT; i++) m_ren[i] = 1'b0;
        for (int i = 0; i < IQ_DEPTH; i++) begin
          b_ok[i]   = 1'b0;
          e_live[i] = 1'b0;
        end
      end
      prev_full  = alu_full;
      open_items = 0;
      for (int i = 0; i < IQ_DEPTH; i++) open_items += int'(e_live[i]);
    end
  end

endmodule

/* rs_top.sv */
`timescale 1ns/1ps

module rs_top
  import rs_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       disp_valid,
  input  tag_t       disp_tag,
  input  opcode_t    disp_opcode,
  input  func3_t     disp_func3,
  input  func7_t     disp_func7,
  input  word_t      disp_imm,
  input  reg_idx_t   disp_rs1,
  input  reg_idx_t   disp_rs2,
  input  reg_idx_t   disp_rd,
  input  word_t      disp_pc,
  input  logic       disp_hold,
  input  logic       cdb_valid,
  input  tag_t       cdb_tag,
  input  word_t      cdb_value,
  input  logic       commit_valid,
  input  reg_idx_t   commit_rd,
  input  tag_t       commit_tag,
  input  word_t      commit_value,
  input  logic       flush,
  input  logic       alu_full,
  output logic       push_valid,
  output tag_t       push_tag,
  output logic       alu_valid,
  output calc_code_t alu_code,
  output word_t      alu_lhs,
  output word_t      alu_rhs,
  output tag_t       alu_tag,
  output logic       wb_valid,
  output tag_t       wb_tag,
  output word_t      wb_result,
  output logic       wb_target_valid,
  output word_t      wb_target
);

  logic    accept;
  logic    rs1_ready;
  logic    rs2_ready;
  word_t   rs1_value;
  word_t   rs2_value;
  tag_t    rs1_tag;
  tag_t    rs2_tag;

  logic    sel_valid;
  tag_t    sel_tag;
  opcode_t sel_opcode;
  func3_t  sel_func3;
  func7_t  sel_func7;
  word_t   sel_lhs;
  word_t   sel_rhs;
  word_t   sel_imm;
  word_t   sel_pc;

  // source lookup and committed state
  rename_table i_rename (
    .clk, .rst, .flush, .accept,
    .disp_rd, .disp_tag, .disp_rs1, .disp_rs2,
    .cdb_valid, .cdb_tag, .cdb_value,
    .commit_valid, .commit_rd, .commit_tag, .commit_value,
    .rs1_ready, .rs2_ready, .rs1_value, .rs2_value, .rs1_tag, .rs2_tag
  );

  station_entries i_entries (
    .clk, .rst, .flush, .disp_valid, .disp_hold,
    .disp_tag, .disp_opcode, .disp_func3, .disp_func7, .disp_imm, .disp_pc,
    .rs1_ready, .rs2_ready, .rs1_value, .rs2_value, .rs1_tag, .rs2_tag,
    .cdb_valid, .cdb_tag, .cdb_value, .alu_full,
    .accept, .sel_valid, .sel_tag, .sel_opcode, .sel_func3, .sel_func7,
    .sel_lhs, .sel_rhs, .sel_imm, .sel_pc,
    .push_valid, .push_tag
  );

  // registered alu request or queue write-back
  issue_encoder i_encoder (
    .clk, .rst, .flush,
    .sel_valid, .sel_tag, .sel_opcode, .sel_func3, .sel_func7,
    .sel_lhs, .sel_rhs, .sel_imm, .sel_pc,
    .alu_valid, .alu_code, .alu_lhs, .alu_rhs, .alu_tag,
    .wb_valid, .wb_tag, .wb_result, .wb_target_valid, .wb_target
  );

endmodule

/* issue_encoder.sv */
`timescale 1ns/1ps

module issue_encoder
  import rs_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       flush,
  input  logic       sel_valid,
  input  tag_t       sel_tag,
  input  opcode_t    sel_opcode,
  input  func3_t     sel_func3,
  input  func7_t     sel_func7,
  input  word_t      sel_lhs,
  input  word_t      sel_rhs,
  input  word_t      sel_imm,
  input  word_t      sel_pc,
  output logic       alu_valid,
  output calc_code_t alu_code,
  output word_t      alu_lhs,
  output word_t      alu_rhs,
  output tag_t       alu_tag,
  output logic       wb_valid,
  output tag_t       wb_tag,
  output word_t      wb_result,
  output logic       wb_target_valid,
  output word_t      wb_target
);

  logic       alu_op;
  logic       direct_op;
  logic       shift_op;
  calc_code_t code;
  word_t      rhs;
  word_t      result;
  word_t      target;

  always_comb begin
    alu_op    = is_alu_class(sel_opcode);
    direct_op = (sel_opcode == OPC_LUI) || (sel_opcode == OPC_AUIPC) ||
                (sel_opcode == OPC_JAL) || (sel_opcode == OPC_JALR);
    shift_op  = (sel_opcode == OPC_CALC || sel_opcode == OPC_CALC_I) &&
                (sel_func3 == 3'd1 || sel_func3 == 3'd5);

    // alu code from func3, func7 only picks sub and sra
    if (sel_opcode == OPC_BRANCH) begin
      code = sel_func3[2] ? calc_code_t'(sel_func3) + 4'd8 : calc_code_t'(sel_func3) + 4'd10;
    end else begin
      case (sel_func3)
        3'd0:    code = (sel_opcode == OPC_CALC && sel_func7 != '0) ? CALC_SUB : CALC_ADD;
        3'd5:    code = (sel_func7 != '0) ? CALC_SRA : CALC_SRL;
        3'd6,
        3'd7:    code = calc_code_t'(sel_func3) + 4'd2;
        default: code = calc_code_t'(sel_func3) + 4'd1;
      endcase
    end

    rhs = (sel_opcode == OPC_CALC_I) ? sel_imm : sel_rhs;
    if (shift_op) begin
      rhs = word_t'(rhs[SHAMT_BITS-1:0]);
    end

    // direct results written back to the instruction queue
    case (sel_opcode)
      OPC_LUI:   result = sel_imm;
      OPC_AUIPC: result = sel_pc + sel_imm;
      default:   result = sel_pc + word_t'(4);
    endcase
    target = (sel_lhs + sel_imm) & ~word_t'(1);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      alu_valid       <= 1'b0;
      wb_valid        <= 1'b0;
      wb_target_valid <= 1'b0;
    end else begin
      alu_valid       <= sel_valid && alu_op && !flush;
      wb_valid        <= sel_valid && direct_op && !flush;
      wb_target_valid <= sel_valid && (sel_opcode == OPC_JALR) && !flush;
    end
  end

  always_ff @(posedge clk) begin
    alu_code  <= code;
    alu_lhs   <= sel_lhs;
    alu_rhs   <= rhs;
    alu_tag   <= sel_tag;
    wb_tag    <= sel_tag;
    wb_result <= result;
    wb_target <= target;
  end

endmodule

/* station_entries.sv */
`timescale 1ns/1ps

module station_entries
  import rs_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    flush,
  input  logic    disp_valid,
  input  logic    disp_hold,
  input  tag_t    disp_tag,
  input  opcode_t disp_opcode,
  input  func3_t  disp_func3,
  input  func7_t  disp_func7,
  input  word_t   disp_imm,
  input  word_t   disp_pc,
  input  logic    rs1_ready,
  input  logic    rs2_ready,
  input  word_t   rs1_value,
  input  word_t   rs2_value,
  input  tag_t    rs1_tag,
  input  tag_t    rs2_tag,
  input  logic    cdb_valid,
  input  tag_t    cdb_tag,
  input  word_t   cdb_value,
  input  logic    alu_full,
  output logic    accept,
  output logic    sel_valid,
  output tag_t    sel_tag,
  output opcode_t sel_opcode,
  output func3_t  sel_func3,
  output func7_t  sel_func7,
  output word_t   sel_lhs,
  output word_t   sel_rhs,
  output word_t   sel_imm,
  output word_t   sel_pc,
  output logic    push_valid,
  output tag_t    push_tag
);

  logic    ent_valid     [RS_DEPTH];
  logic    ent_rs1_ready [RS_DEPTH];
  logic    ent_rs2_ready [RS_DEPTH];
  tag_t    ent_tag       [RS_DEPTH];
  opcode_t ent_opcode    [RS_DEPTH];
  func3_t  ent_func3     [RS_DEPTH];
  func7_t  ent_func7     [RS_DEPTH];
  word_t   ent_imm       [RS_DEPTH];
  word_t   ent_pc        [RS_DEPTH];
  word_t   ent_rs1_value [RS_DEPTH];
  word_t   ent_rs2_value [RS_DEPTH];
  tag_t    ent_rs1_tag   [RS_DEPTH];
  tag_t    ent_rs2_tag   [RS_DEPTH];

  logic          free_found;
  rs_idx_t       free_idx;
  rs_idx_t       sel_idx;
  logic [RS_DEPTH-1:0] wake1;
  logic [RS_DEPTH-1:0] wake2;

  always_comb begin
    free_found = 1'b0;
    free_idx   = '0;
    sel_valid  = 1'b0;
    sel_idx    = '0;
    // scan downwards so the lowest index wins
    for (int i = RS_DEPTH - 1; i >= 0; i--) begin
      if (!ent_valid[i]) begin
        free_found = 1'b1;
        free_idx   = rs_idx_t'(i);
      end
      if (ent_valid[i] && ent_rs1_ready[i] && ent_rs2_ready[i] &&
          !(alu_full && is_alu_class(ent_opcode[i]))) begin
        sel_valid = 1'b1;
        sel_idx   = rs_idx_t'(i);
      end
    end
  end

  // operands waiting on the tag now on the cdb
  always_comb begin
    for (int i = 0; i < RS_DEPTH; i++) begin
      wake1[i] = cdb_valid && ent_valid[i] && !ent_rs1_ready[i] && ent_rs1_tag[i] == cdb_tag;
      wake2[i] = cdb_valid && ent_valid[i] && !ent_rs2_ready[i] && ent_rs2_tag[i] == cdb_tag;
    end
  end

  assign accept = disp_valid && !disp_hold && !flush && free_found;

  assign sel_tag    = ent_tag[sel_idx];
  assign sel_opcode = ent_opcode[sel_idx];
  assign sel_func3  = ent_func3[sel_idx];
  assign sel_func7  = ent_func7[sel_idx];
  assign sel_lhs    = ent_rs1_value[sel_idx];
  assign sel_rhs    = ent_rs2_value[sel_idx];
  assign sel_imm    = ent_imm[sel_idx];
  assign sel_pc     = ent_pc[sel_idx];

  always_ff @(posedge clk) begin
    if (rst) begin
      push_valid <= 1'b0;
      for (int i = 0; i < RS_DEPTH; i++) begin
        ent_valid[i]     <= 1'b0;
        ent_rs1_ready[i] <= 1'b0;
        ent_rs2_ready[i] <= 1'b0;
      end
    end else begin
      push_valid <= accept;
      for (int i = 0; i < RS_DEPTH; i++) begin
        if (wake1[i]) ent_rs1_ready[i] <= 1'b1;
        if (wake2[i]) ent_rs2_ready[i] <= 1'b1;
      end
      // the selected entry leaves as it is handed to the encoder
      if (sel_valid) begin
        ent_valid[sel_idx] <= 1'b0;
      end
      if (accept) begin
        ent_valid[free_idx]     <= 1'b1;
        ent_rs1_ready[free_idx] <= rs1_ready;
        ent_rs2_ready[free_idx] <= rs2_ready;
      end
      if (flush) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
          ent_valid[i] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < RS_DEPTH; i++) begin
      if (wake1[i]) ent_rs1_value[i] <= cdb_value;
      if (wake2[i]) ent_rs2_value[i] <= cdb_value;
    end
    if (accept) begin
      push_tag                <= disp_tag;
      ent_tag[free_idx]       <= disp_tag;
      ent_opcode[free_idx]    <= disp_opcode;
      ent_func3[free_idx]     <= disp_func3;
      ent_func7[free_idx]     <= disp_func7;
      ent_imm[free_idx]       <= disp_imm;
      ent_pc[free_idx]        <= disp_pc;
      ent_rs1_value[free_idx] <= rs1_value;
      ent_rs2_value[free_idx] <= rs2_value;
      ent_rs1_tag[free_idx]   <= rs1_tag;
      ent_rs2_tag[free_idx]   <= rs2_tag;
    end
  end

endmodule

/* rename_table.sv */
`timescale 1ns/1ps

module rename_table
  import rs_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     flush,
  input  logic     accept,
  input  reg_idx_t disp_rd,
  input  tag_t     disp_tag,
  input  reg_idx_t disp_rs1,
  input  reg_idx_t disp_rs2,
  input  logic     cdb_valid,
  input  tag_t     cdb_tag,
  input  word_t    cdb_value,
  input  logic     commit_valid,
  input  reg_idx_t commit_rd,
  input  tag_t     commit_tag,
  input  word_t    commit_value,
  output logic     rs1_ready,
  output logic     rs2_ready,
  output word_t    rs1_value,
  output word_t    rs2_value,
  output tag_t     rs1_tag,
  output tag_t     rs2_tag
);

  // committed register file and rename state
  word_t reg_val     [REG_COUNT];
  logic  reg_renamed [REG_COUNT];
  tag_t  reg_tag     [REG_COUNT];

  // results already on the cdb but not yet committed
  word_t buf_value [IQ_DEPTH];
  logic  buf_valid [IQ_DEPTH];

  // resolve one source register, with bypass of this cycle's cdb and commit
  function automatic void lookup(input reg_idx_t r, output logic rdy, output word_t val,
                                 output tag_t tag);
    tag = reg_tag[r];
    rdy = 1'b1;
    val = reg_val[r];
    if (r == '0) begin
      val = '0;
    end else if (reg_renamed[r]) begin
      if (cdb_valid && cdb_tag == tag) begin
        val = cdb_value;
      end else if (commit_valid && commit_tag == tag) begin
        val = commit_value;
      end else if (buf_valid[tag]) begin
        val = buf_value[tag];
      end else begin
        rdy = 1'b0;
      end
    end
  endfunction

  always_comb begin
    lookup(disp_rs1, rs1_ready, rs1_value, rs1_tag);
    lookup(disp_rs2, rs2_ready, rs2_value, rs2_tag);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        reg_val[i]     <= '0;
        reg_renamed[i] <= 1'b0;
      end
      for (int i = 0; i < IQ_DEPTH; i++) begin
        buf_valid[i] <= 1'b0;
      end
    end else begin
      if (cdb_valid) begin
        buf_valid[cdb_tag] <= 1'b1;
      end
      if (commit_valid) begin
        buf_valid[commit_tag] <= 1'b0;
        if (commit_rd != '0) begin
          reg_val[commit_rd] <= commit_value;
          // only the newest rename of rd may be released
          if (reg_renamed[commit_rd] && reg_tag[commit_rd] == commit_tag) begin
            reg_renamed[commit_rd] <= 1'b0;
          end
        end
      end
      // a new rename overrides a commit to the same register
      if (accept) begin
        buf_valid[disp_tag] <= 1'b0;
        if (disp_rd != '0) begin
          reg_renamed[disp_rd] <= 1'b1;
        end
      end
      if (flush) begin
        for (int i = 0; i < REG_COUNT; i++) begin
          reg_renamed[i] <= 1'b0;
        end
        for (int i = 0; i < IQ_DEPTH; i++) begin
          buf_valid[i] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cdb_valid) begin
      buf_value[cdb_tag] <= cdb_value;
    end
    if (accept && disp_rd != '0) begin
      reg_tag[disp_rd] <= disp_tag;
    end
  end

endmodule

/* rs_pkg.sv */
package rs_pkg;

  // datapath and storage sizes
  localparam int XLEN       = 32;
  localparam int REG_COUNT  = 32;
  localparam int IQ_DEPTH   = 16;
  localparam int RS_DEPTH   = 8;
  localparam int SHAMT_BITS = 5;

  typedef logic [XLEN-1:0]              word_t;
  typedef logic [$clog2(IQ_DEPTH)-1:0]  tag_t;
  typedef logic [$clog2(REG_COUNT)-1:0] reg_idx_t;
  typedef logic [$clog2(RS_DEPTH)-1:0]  rs_idx_t;
  typedef logic [6:0]                   opcode_t;
  typedef logic [2:0]                   func3_t;
  typedef logic [6:0]                   func7_t;
  typedef logic [3:0]                   calc_code_t;

  // major opcodes handled by the station
  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_AUIPC  = 7'b0010111;
  localparam opcode_t OPC_JAL    = 7'b1101111;
  localparam opcode_t OPC_JALR   = 7'b1100111;
  localparam opcode_t OPC_BRANCH = 7'b1100011;
  localparam opcode_t OPC_CALC_I = 7'b0010011;
  localparam opcode_t OPC_CALC   = 7'b0110011;

  // named alu codes, the rest are derived from func3
  localparam calc_code_t CALC_ADD = 4'd0;
  localparam calc_code_t CALC_SUB = 4'd1;
  localparam calc_code_t CALC_SRL = 4'd6;
  localparam calc_code_t CALC_SRA = 4'd7;

  // ops that need the alu, everything else is finished in the station
  function automatic logic is_alu_class(input opcode_t op);
    logic hit;
    hit = (op == OPC_CALC) || (op == OPC_CALC_I) || (op == OPC_BRANCH);
    return hit;
  endfunction

endpackage
